// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= wb_soc_tb
FILELIST  ?= wb_soc.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/wb_soc_asserts.sv
module wb_soc_asserts (
    input logic                i_clk,
    input logic                i_reset,
    input wb_soc_pkg::wb_req_t i_dbus_req,
    input wb_soc_pkg::wb_req_t i_ibus_req,
    input wb_soc_pkg::wb_req_t i_dbg_req,
    input wb_soc_pkg::wb_rsp_t i_dbus_rsp,
    input wb_soc_pkg::wb_rsp_t i_ibus_rsp,
    input wb_soc_pkg::wb_rsp_t i_dbg_rsp,
    input wb_soc_pkg::wb_rsp_t i_mbus_rsp,
    input logic                i_ram_stb,
    input logic                i_regs_stb
);
    // ports asking and not held off
    logic [2:0] granted;
    // some port has a cycle open
    logic       any_cyc;

    assign granted = {i_dbg_req.cyc && !i_dbg_rsp.stall,
                      i_ibus_req.cyc && !i_ibus_rsp.stall,
                      i_dbus_req.cyc && !i_dbus_rsp.stall};
    assign any_cyc = i_dbus_req.cyc || i_ibus_req.cyc || i_dbg_req.cyc;

    // ack and err exclusive per port
    assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_dbus_rsp.ack && i_dbus_rsp.err) && !(i_ibus_rsp.ack && i_ibus_rsp.err) &&
        !(i_dbg_rsp.ack && i_dbg_rsp.err))
        else $error("ack and err high together on a master port");

    // while anyone asks, the owner runs free and every other port waits
    assert property (@(posedge i_clk) disable iff (i_reset)
        any_cyc |-> $onehot(granted))
        else $error("owner port stalled or two ports granted");

    // slave ack plus decoder register
    assert property (@(posedge i_clk) disable iff (i_reset)
        i_mbus_rsp.ack |-> $past(i_ram_stb || i_regs_stb, 2))
        else $error("master-bus ack without a slave strobe two cycles earlier");

endmodule

bind wb_soc_top wb_soc_asserts asserts_i (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_dbus_req (i_dbus_req),
    .i_ibus_req (i_ibus_req),
    .i_dbg_req  (i_dbg_req),
    .i_dbus_rsp (o_dbus_rsp),
    .i_ibus_rsp (o_ibus_rsp),
    .i_dbg_rsp  (o_dbg_rsp),
    .i_mbus_rsp (mbus_rsp),
    .i_ram_stb  (ram_stb),
    .i_regs_stb (regs_stb)
);

// File: bench/wb_soc_tb.sv
module wb_soc_tb;
    import wb_soc_pkg::*;

    localparam int clk_period = 8;
    localparam int n_gap = 40;
    // about 60 accesses of at most 20 cycles, plus the counter gap and slack
    localparam int watchdog_cycles = 60 * 20 + n_gap + 760;
    localparam logic [31:0] version_word = 32'h20191028;

    logic        i_clk;
    logic        i_reset;
    logic        o_irq;
    // port 0 data, 1 fetch, 2 debug
    wb_req_t     req [3];
    wb_rsp_t     dbus_rsp;
    wb_rsp_t     ibus_rsp;
    wb_rsp_t     dbg_rsp;
    // outcome of the last access on each port
    logic [31:0] rd_dat [3];
    logic        got_err [3];
    int          latency [3];
    int          stalls [3];
    time         t_accept [3];
    time         t_release [3];
    logic [31:0] ram_model [16];
    int          errors;

    wb_soc_top #(
        .RAM_AW (10)
    ) wb_soc_top_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_dbus_req (req[0]),
        .o_dbus_rsp (dbus_rsp),
        .i_ibus_req (req[1]),
        .o_ibus_rsp (ibus_rsp),
        .i_dbg_req  (req[2]),
        .o_dbg_rsp  (dbg_rsp),
        .o_irq      (o_irq)
    );

    initial begin
        i_clk = 1'b0;
    end

    always #(clk_period / 2) i_clk = ~i_clk;

    function automatic wb_rsp_t port_rsp(input int p);
        case (p)
            0: return dbus_rsp;
            1: return ibus_rsp;
            default: return dbg_rsp;
        endcase
    endfunction

    // region 0 is ram, region 1 the register block
    function automatic logic [29:0] ram_adr(input int w);
        return {9'd0, 21'(w)};
    endfunction

    function automatic logic [29:0] reg_adr(input int idx);
        return {9'd1, 17'd0, 4'(idx)};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("%0t: %s", $time, msg);
            errors++;
        end
    endtask

    // single access, called and returning 1 unit after a rising edge
    task automatic bus_access(input int p, input logic we, input logic [29:0] adr,
                              input logic [31:0] dat, input logic [3:0] sel);
        wb_rsp_t r;
        req[p] = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
        stalls[p] = 0;
        // stall seen at the falling edge holds for the next rising one
        @(negedge i_clk);
        r = port_rsp(p);
        while (r.stall) begin
            stalls[p]++;
            @(negedge i_clk);
            r = port_rsp(p);
        end
        @(posedge i_clk);
        t_accept[p] = $time;
        #1;
        req[p].stb = 1'b0;
        latency[p] = 0;
        // count edges from accept until ack or err
        do begin
            @(negedge i_clk);
            latency[p]++;
            r = port_rsp(p);
        end while (!r.ack && !r.err);
        rd_dat[p] = r.dat;
        got_err[p] = r.err;
        @(posedge i_clk);
        #1;
        req[p] = '0;
        t_release[p] = $time;
    endtask

    task automatic write_word(input int p, input logic [29:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel);
        bus_access(p, 1'b1, adr, dat, sel);
        check_val($sformatf("port%0d rsp.err", p), 32'(got_err[p]), 32'd0);
        check_val($sformatf("port%0d ack latency", p), 32'(latency[p]), 32'd2);
    endtask

    task automatic read_word(input int p, input logic [29:0] adr, input logic [31:0] exp);
        bus_access(p, 1'b0, adr, 32'h0, 4'hf);
        check_val($sformatf("port%0d rsp.err", p), 32'(got_err[p]), 32'd0);
        check_val($sformatf("port%0d ack latency", p), 32'(latency[p]), 32'd2);
        check_val($sformatf("port%0d rsp.dat", p), rd_dat[p], exp);
    endtask

    task automatic ram_data_port_test();
        logic [31:0] wdat;
        for (int i = 0; i < 16; i++) begin
            ram_model[i] = $urandom;
            write_word(0, ram_adr(i), ram_model[i], 4'hf);
        end
        for (int i = 0; i < 16; i++) begin
            read_word(0, ram_adr(i), ram_model[i]);
        end
        // lanes 0 and 2 only
        wdat = $urandom;
        write_word(0, ram_adr(3), wdat, 4'b0101);
        ram_model[3] = {ram_model[3][31:24], wdat[23:16], ram_model[3][15:8], wdat[7:0]};
        read_word(0, ram_adr(3), ram_model[3]);
        // top lane only
        wdat = $urandom;
        write_word(0, ram_adr(9), wdat, 4'b1000);
        ram_model[9] = {wdat[31:24], ram_model[9][23:0]};
        read_word(0, ram_adr(9), ram_model[9]);
    endtask

    task automatic sys_regs_debug_test();
        read_word(2, reg_adr(0), version_word);
        write_word(2, reg_adr(1), 32'h5ca7_c41e, 4'hf);
        read_word(2, reg_adr(1), 32'h5ca7_c41e);
        // irq flag follows bit 0
        write_word(2, reg_adr(4), 32'h1, 4'hf);
        check_val("o_irq", 32'(o_irq), 32'd1);
        read_word(2, reg_adr(4), 32'h1);
        write_word(2, reg_adr(4), 32'h0, 4'hf);
        check_val("o_irq", 32'(o_irq), 32'd0);
        read_word(2, reg_adr(9), 32'h0);
    endtask

    task automatic bus_error_test();
        logic [29:0] bad_adr;
        bad_adr = {9'd5, 21'h0_4a3c};
        bus_access(0, 1'b0, bad_adr, 32'h0, 4'hf);
        check_val("port0 rsp.err", 32'(got_err[0]), 32'd1);
        check_val("port0 err latency", 32'(latency[0]), 32'd1);
        // no late ack may follow the err
        repeat (3) begin
            @(negedge i_clk);
            check_val("port0 rsp.ack", 32'(dbus_rsp.ack), 32'd0);
        end
        @(posedge i_clk);
        #1;
        read_word(1, reg_adr(2), 32'(bad_adr) * 32'd4);
    endtask

    task automatic power_counter_test();
        logic [31:0] first;
        bus_access(2, 1'b0, reg_adr(3), 32'h0, 4'hf);
        first = rd_dat[2];
        repeat (n_gap) @(posedge i_clk);
        #1;
        bus_access(2, 1'b0, reg_adr(3), 32'h0, 4'hf);
        check_true(first != 32'd0, "power counter still zero long after reset");
        check_true(rd_dat[2] - first >= 32'(n_gap), "power counter advanced less than the gap");
    endtask

    task automatic priority_test();
        // data writes a word while fetch reads it back
        fork
            bus_access(0, 1'b1, ram_adr(20), 32'hc0de_f00d, 4'hf);
            bus_access(1, 1'b0, ram_adr(20), 32'h0, 4'hf);
        join
        check_true(stalls[0] == 0, "data port stalled against the fetch port");
        check_true(stalls[1] > 0, "fetch port never stalled while data port held the bus");
        check_true(t_accept[1] > t_release[0], "fetch port granted before data port dropped cyc");
        check_val("port1 rsp.dat", rd_dat[1], 32'hc0de_f00d);
        // fetch against debug, one level up
        fork
            bus_access(1, 1'b0, ram_adr(20), 32'h0, 4'hf);
            bus_access(2, 1'b0, ram_adr(3), 32'h0, 4'hf);
        join
        check_true(stalls[1] == 0, "fetch port stalled against the debug port");
        check_true(stalls[2] > 0, "debug port never stalled while fetch port held the bus");
        check_true(t_accept[2] > t_release[1], "debug port granted before fetch port dropped cyc");
        check_val("port1 rsp.dat", rd_dat[1], 32'hc0de_f00d);
        check_val("port2 rsp.dat", rd_dat[2], ram_model[3]);
    endtask

    initial begin
        void'($urandom(32'h4c73));
        errors = 0;
        i_reset = 1'b1;
        for (int i = 0; i < 3; i++) begin
            req[i] = '0;
        end
        repeat (4) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        check_val("o_dbus_rsp ack/err/stall", 32'({dbus_rsp.ack, dbus_rsp.err, dbus_rsp.stall}),
                  32'd0);
        check_val("o_irq", 32'(o_irq), 32'd0);
        ram_data_port_test();
        sys_regs_debug_test();
        bus_error_test();
        power_counter_test();
        priority_test();
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge i_clk);
        $display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: src/bus_decoder.sv
module bus_decoder (
    input  logic                           i_clk,
    input  logic                           i_reset,
    // master bus
    input  wb_soc_pkg::wb_req_t            i_req,
    output wb_soc_pkg::wb_rsp_t            o_rsp,
    // ram slave
    output logic                           o_ram_stb,
    input  logic                           i_ram_ack,
    input  logic [wb_soc_pkg::wb_dat_w-1:0] i_ram_dat,
    // system register slave
    output logic                           o_regs_stb,
    input  logic                           i_regs_ack,
    input  logic [wb_soc_pkg::wb_dat_w-1:0] i_regs_dat,
    // unmapped access, one cycle pulse
    output logic                           o_err_stb
);
    import wb_soc_pkg::*;

    logic [region_w-1:0] region;
    logic                ram_sel;
    logic                regs_sel;
    // request accepted this edge
    logic                accept;

    // registered response
    logic                ack_q;
    logic                err_q;
    logic [wb_dat_w-1:0] dat_q;

    // region from the top address bits
    assign region = i_req.adr[wb_adr_w-1:region_lsb];
    assign ram_sel = (region == region_ram);
    assign regs_sel = (region == region_regs);

    // no slave stalls, so every strobe inside a cycle is taken
    assign accept = i_req.cyc && i_req.stb && !o_rsp.stall;

    assign o_ram_stb = accept && ram_sel;
    assign o_regs_stb = accept && regs_sel;
    // nobody lives here
    // sys_regs grabs the address in this same cycle
    assign o_err_stb = accept && !ram_sel && !regs_sel;

    // err one cycle after the bad strobe
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            err_q <= 1'b0;
        end else begin
            err_q <= o_err_stb;
        end
    end

    // slaves ack one cycle after strobe, one more here
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= i_ram_ack || i_regs_ack;
        end
    end

    // return data, register block wins
    always_ff @(posedge i_clk) begin
        if (i_regs_ack) begin
            dat_q <= i_regs_dat;
        end else if (i_ram_ack) begin
            dat_q <= i_ram_dat;
        end else begin
            dat_q <= '0;
        end
    end

    always_comb begin
        o_rsp.ack = ack_q;
        o_rsp.err = err_q;
        // back-pressure only comes from the arbiters
        o_rsp.stall = 1'b0;
        o_rsp.dat = dat_q;
    end

endmodule

// File: src/sys_regs.sv
module sys_regs (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_stb,
    input  wb_soc_pkg::wb_req_t             i_req,
    // unmapped access seen on the master bus
    input  logic                            i_err_stb,
    output logic                            o_ack,
    output logic [wb_soc_pkg::wb_dat_w-1:0] o_dat,
    output logic                            o_irq
);
    import wb_soc_pkg::*;

    logic [regsel_w-1:0] regsel;
    logic [wb_dat_w-1:0] scratch;
    logic [wb_adr_w-1:0] err_adr;
    logic [wb_dat_w-1:0] pwr_cnt;
    logic                irq_flag;

    assign regsel = i_req.adr[regsel_w-1:0];

    // ack one cycle after strobe, no wait states
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_stb;
        end
    end

    // scratch, byte lanes honored
    always_ff @(posedge i_clk) begin
        if (i_stb && i_req.we && (regsel == reg_scratch)) begin
            for (int i = 0; i < wb_sel_w; i++) begin
                if (i_req.sel[i]) begin
                    scratch[8*i +: 8] <= i_req.dat[8*i +: 8];
                end
            end
        end
    end

    // interrupt flag and last error word address
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            irq_flag <= 1'b0;
            err_adr <= '0;
        end else begin
            if (i_stb && i_req.we && (regsel == reg_irq)) begin
                irq_flag <= i_req.dat[0];
            end
            if (i_err_stb) begin
                err_adr <= i_req.adr;
            end
        end
    end

    // clocks since reset
    // top bit is sticky, the rest wraps
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pwr_cnt <= '0;
        end else if (!pwr_cnt[wb_dat_w-1]) begin
            pwr_cnt <= pwr_cnt + 1'b1;
        end else begin
            pwr_cnt[wb_dat_w-2:0] <= pwr_cnt[wb_dat_w-2:0] + 1'b1;
        end
    end

    // read mux, registered
    always_ff @(posedge i_clk) begin
        case (regsel)
            reg_version: o_dat <= sys_version;
            reg_scratch: o_dat <= scratch;
            // word address back as byte address
            reg_err_adr: o_dat <= {err_adr, 2'b00};
            reg_pwr_cnt: o_dat <= pwr_cnt;
            reg_irq:     o_dat <= {{(wb_dat_w-1){1'b0}}, irq_flag};
            default:     o_dat <= '0;
        endcase
    end

    assign o_irq = irq_flag;

endmodule

// File: src/wb_pri_arbiter.sv
module wb_pri_arbiter (
    input  logic                i_clk,
    input  logic                i_reset,
    // A, the high priority master
    input  wb_soc_pkg::wb_req_t i_a_req,
    output wb_soc_pkg::wb_rsp_t o_a_rsp,
    // B, the low priority master
    input  wb_soc_pkg::wb_req_t i_b_req,
    output wb_soc_pkg::wb_rsp_t o_b_rsp,
    // merged bus toward the slaves
    output wb_soc_pkg::wb_req_t o_req,
    input  wb_soc_pkg::wb_rsp_t i_rsp
);
    import wb_soc_pkg::*;

    // 1 while B holds the bus
    logic owner_b;
    // who drives the merged bus this cycle
    logic a_grant;
    wb_req_t sel_req;

    // ownership only moves while the owner has cyc low
    // an idle bus goes to A whenever A asks
    always_comb begin
        if (owner_b) begin
            a_grant = !i_b_req.cyc;
        end else begin
            a_grant = i_a_req.cyc || !i_b_req.cyc;
        end
    end

    // remember the grant so a cycle is never split
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            owner_b <= 1'b0;
        end else begin
            owner_b <= !a_grant;
        end
    end

    // request mux, no added latency
    assign sel_req = a_grant ? i_a_req : i_b_req;

    always_comb begin
        o_req = sel_req;
        // stb only valid inside a cycle
        o_req.stb = sel_req.cyc && sel_req.stb;
    end

    // response steering
    always_comb begin
        o_a_rsp = '0;
        o_b_rsp = '0;
        // read data goes to both, only the owner gets the ack
        o_a_rsp.dat = i_rsp.dat;
        o_b_rsp.dat = i_rsp.dat;
        if (a_grant) begin
            o_a_rsp.ack = i_rsp.ack;
            o_a_rsp.err = i_rsp.err;
            o_a_rsp.stall = i_rsp.stall;
            // B waits as long as it asks
            o_b_rsp.stall = i_b_req.cyc;
        end else begin
            o_b_rsp.ack = i_rsp.ack;
            o_b_rsp.err = i_rsp.err;
            o_b_rsp.stall = i_rsp.stall;
            o_a_rsp.stall = i_a_req.cyc;
        end
    end

endmodule

// File: src/wb_ram.sv
module wb_ram #(
    // word address width, 2**RAM_AW words
    parameter int RAM_AW = 10
) (
    input  logic                            i_clk,
    input  logic                            i_stb,
    input  wb_soc_pkg::wb_req_t             i_req,
    output logic                            o_ack,
    output logic [wb_soc_pkg::wb_dat_w-1:0] o_dat
);
    import wb_soc_pkg::*;

    localparam int depth = 1 << RAM_AW;

    logic [wb_dat_w-1:0] mem [0:depth-1];
    // low word address bits only, region bits already decoded
    logic [RAM_AW-1:0]   word_adr;

    assign word_adr = i_req.adr[RAM_AW-1:0];

    // byte lane writes
    always_ff @(posedge i_clk) begin
        if (i_stb && i_req.we) begin
            for (int i = 0; i < wb_sel_w; i++) begin
                if (i_req.sel[i]) begin
                    mem[word_adr][8*i +: 8] <= i_req.dat[8*i +: 8];
                end
            end
        end
    end

    // registered read
    // a write returns the old word
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_dat <= mem[word_adr];
        end
    end

    // single cycle response, never stalls
    always_ff @(posedge i_clk) begin
        o_ack <= i_stb;
    end

endmodule

// File: src/wb_soc_pkg.sv
package wb_soc_pkg;

    // word addressed bus, 32-bit data
    localparam int wb_adr_w = 30;
    localparam int wb_dat_w = 32;
    // one select per byte lane
    localparam int wb_sel_w = 4;

    // master side of a pipelined wishbone port
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [wb_adr_w-1:0] adr;
        logic [wb_dat_w-1:0] dat;
        logic [wb_sel_w-1:0] sel;
    } wb_req_t;

    // slave side, back to the master
    typedef struct packed {
        logic                ack;
        logic                stall;
        logic                err;
        logic [wb_dat_w-1:0] dat;
    } wb_rsp_t;

    // memory map
    // top address bits pick a region, adr[29:21]
    localparam int region_w = 9;
    localparam int region_lsb = wb_adr_w - region_w;

    // 8 MB of ram window
    localparam logic [region_w-1:0] region_ram = 9'd0;
    // system registers sit right above it
    localparam logic [region_w-1:0] region_regs = 9'd1;

    // system register block
    // register index width inside the block
    localparam int regsel_w = 4;

    // register 0 reads this
    localparam logic [wb_dat_w-1:0] sys_version = 32'h20191028;

    // register indices
    localparam logic [regsel_w-1:0] reg_version = 4'h0;
    localparam logic [regsel_w-1:0] reg_scratch = 4'h1;
    localparam logic [regsel_w-1:0] reg_err_adr = 4'h2;
    localparam logic [regsel_w-1:0] reg_pwr_cnt = 4'h3;
    localparam logic [regsel_w-1:0] reg_irq = 4'h4;

endpackage

// File: src/wb_soc_top.sv
module wb_soc_top #(
    parameter int RAM_AW = 10
) (
    input  logic                i_clk,
    input  logic                i_reset,
    // data port, highest priority
    input  wb_soc_pkg::wb_req_t i_dbus_req,
    output wb_soc_pkg::wb_rsp_t o_dbus_rsp,
    // instruction fetch port
    input  wb_soc_pkg::wb_req_t i_ibus_req,
    output wb_soc_pkg::wb_rsp_t o_ibus_rsp,
    // debug port, lowest priority
    input  wb_soc_pkg::wb_req_t i_dbg_req,
    output wb_soc_pkg::wb_rsp_t o_dbg_rsp,
    output logic                o_irq
);
    import wb_soc_pkg::*;

    // internal bus, data and fetch merged
    wb_req_t ibus_req;
    wb_rsp_t ibus_rsp;
    // master bus toward the decoder
    wb_req_t mbus_req;
    wb_rsp_t mbus_rsp;

    // slave side
    logic                ram_stb;
    logic                ram_ack;
    logic [wb_dat_w-1:0] ram_dat;
    logic                regs_stb;
    logic                regs_ack;
    logic [wb_dat_w-1:0] regs_dat;
    logic                err_stb;

    // data over fetch
    wb_pri_arbiter ibus_arbiter (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_a_req (i_dbus_req),
        .o_a_rsp (o_dbus_rsp),
        .i_b_req (i_ibus_req),
        .o_b_rsp (o_ibus_rsp),
        .o_req   (ibus_req),
        .i_rsp   (ibus_rsp)
    );

    // cpu side over debug
    wb_pri_arbiter mbus_arbiter (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_a_req (ibus_req),
        .o_a_rsp (ibus_rsp),
        .i_b_req (i_dbg_req),
        .o_b_rsp (o_dbg_rsp),
        .o_req   (mbus_req),
        .i_rsp   (mbus_rsp)
    );

    bus_decoder decoder (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_req      (mbus_req),
        .o_rsp      (mbus_rsp),
        .o_ram_stb  (ram_stb),
        .i_ram_ack  (ram_ack),
        .i_ram_dat  (ram_dat),
        .o_regs_stb (regs_stb),
        .i_regs_ack (regs_ack),
        .i_regs_dat (regs_dat),
        .o_err_stb  (err_stb)
    );

    sys_regs regs (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_stb     (regs_stb),
        .i_req     (mbus_req),
        .i_err_stb (err_stb),
        .o_ack     (regs_ack),
        .o_dat     (regs_dat),
        .o_irq     (o_irq)
    );

    wb_ram #(
        .RAM_AW (RAM_AW)
    ) ram (
        .i_clk (i_clk),
        .i_stb (ram_stb),
        .i_req (mbus_req),
        .o_ack (ram_ack),
        .o_dat (ram_dat)
    );

endmodule

// File: wb_soc.f
src/wb_soc_pkg.sv
src/wb_pri_arbiter.sv
src/bus_decoder.sv
src/sys_regs.sv
src/wb_ram.sv
src/wb_soc_top.sv
bench/wb_soc_asserts.sv
bench/wb_soc_tb.sv
